/* common/matmul_consts.svh */
`ifndef MATMUL_CONSTS_SVH
`define MATMUL_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Data and address widths
////////////////////////////////////////////////////////////////////////////

// Width of one matrix element
`define DWIDTH 8

// External memory address width
`define AWIDTH 10

// Stride inputs are narrower than addresses and get zero extended
`define ADDR_STRIDE_WIDTH 8

////////////////////////////////////////////////////////////////////////////
// Array geometry and pipeline depths
////////////////////////////////////////////////////////////////////////////

// Lanes per side of the mesh, which is also the number of fetches per matrix
`define MAT_MUL_SIZE 4

// Operand register, product register and accumulator
`define NUM_CYCLES_IN_MAC 3

// Cycles from address to returned word on the memory side
`define MEM_ACCESS_LATENCY 1

////////////////////////////////////////////////////////////////////////////
// Sequencing points, in counter cycles after start
////////////////////////////////////////////////////////////////////////////

// PE33 has taken its last product by about cycle 14
`define LATCH_CYCLE 16
`define DONE_CYCLE 21

`endif

/* common/matmul_pkg.sv */
`default_nettype none

`include "matmul_consts.svh"

package matmul_pkg;

    // One matrix element
    typedef logic [`DWIDTH-1:0] elem_t;

    // Four elements side by side, lane 0 sits in the low byte
    typedef elem_t [`MAT_MUL_SIZE-1:0] lane_vec_t;

    // Memory address into the A, B or C region
    typedef logic [`AWIDTH-1:0] addr_t;

    // Distance between two consecutive columns or rows in memory
    typedef logic [`ADDR_STRIDE_WIDTH-1:0] stride_t;

    // One validity bit per lane or per inner term
    typedef logic [`MAT_MUL_SIZE-1:0] mask_t;

    // Sequencing counter, far wider than the few dozen cycles a block needs
    typedef logic [7:0] cycle_cnt_t;

endpackage

`default_nettype wire

/* hdl/matmul_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_control
    import matmul_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start_mat_mul,
    output logic fetch_en,
    output logic row_latch_en,
    output logic done_mat_mul
);

    cycle_cnt_t clk_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing counter
    ////////////////////////////////////////////////////////////////////////////

    // Zero in the first cycle start is high, then one step per cycle.
    // The counter parks one past the done cycle so done stays a single pulse
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            clk_cnt <= '0;
        end
        else if (clk_cnt <= cycle_cnt_t'(`DONE_CYCLE))
        begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decodes
    ////////////////////////////////////////////////////////////////////////////

    // One fetch per lane for A and B in parallel
    assign fetch_en = start_mat_mul && (clk_cnt < cycle_cnt_t'(`MAT_MUL_SIZE));

    // Results are stable in every PE by this point
    assign row_latch_en = start_mat_mul && (clk_cnt == cycle_cnt_t'(`LATCH_CYCLE));

    // The last C column leaves the shifter in the cycle before this
    assign done_mat_mul = start_mat_mul && (clk_cnt == cycle_cnt_t'(`DONE_CYCLE));

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // A run finishes exactly once, even while start is still held high
    done_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul
    );

endmodule

`default_nettype wire

/* hdl/operand_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module operand_feeder
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  logic      fetch_en,
    input  addr_t     base_addr,
    input  stride_t   stride,
    input  mask_t     lane_mask,
    input  mask_t     term_mask,
    input  lane_vec_t mem_data,
    output addr_t     mem_addr,
    output lane_vec_t skewed_lanes
);

    localparam int LAT   = `MEM_ACCESS_LATENCY;
    localparam int IDX_W = $clog2(`MAT_MUL_SIZE);

    // Bit 0 is high while an address sits on the bus, bit LAT while its word is back
    logic [LAT:0]     fetch_pipe;
    logic [IDX_W-1:0] term_idx;
    logic             term_live;
    lane_vec_t        masked;

    ////////////////////////////////////////////////////////////////////////////
    // Address generation and fetch tracking
    ////////////////////////////////////////////////////////////////////////////

    // The first fetch cycle loads the base, the following ones step by the stride
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            mem_addr   <= base_addr;
            fetch_pipe <= '0;
            term_idx   <= '0;
        end
        else
        begin
            fetch_pipe <= {fetch_pipe[LAT-1:0], fetch_en};
            if (fetch_en)
            begin
                if (fetch_pipe[0])
                    mem_addr <= mem_addr + addr_t'(stride);
                else
                    mem_addr <= base_addr;
            end
            if (fetch_pipe[LAT])
                term_idx <= term_idx + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Masking and skew
    ////////////////////////////////////////////////////////////////////////////

    // Returned word k counts only if inner term k is valid
    assign term_live = fetch_pipe[LAT] && term_mask[term_idx];

    always_comb
    begin
        for (int i = 0; i < `MAT_MUL_SIZE; i++)
            masked[i] = (term_live && lane_mask[i]) ? mem_data[i] : '0;
    end

    // Lane 0 goes straight into the mesh
    assign skewed_lanes[0] = masked[0];

    // Lane i waits i cycles so the operands meet diagonally in the mesh
    for (genvar i = 1; i < `MAT_MUL_SIZE; i++)
    begin : g_skew
        elem_t dly [i];

        always_ff @(posedge clk)
        begin
            if (reset || !start_mat_mul)
            begin
                for (int d = 0; d < i; d++)
                    dly[d] <= '0;
            end
            else
            begin
                dly[0] <= masked[i];
                for (int d = 1; d < i; d++)
                    dly[d] <= dly[d-1];
            end
        end

        assign skewed_lanes[i] = dly[i-1];
    end

    // The address only moves on the edge that closes a fetch cycle
    addr_moves_on_fetch: assert property (
        @(posedge clk) disable iff (reset)
        (!$past(reset) && $past(start_mat_mul) && $changed(mem_addr)) |-> $past(fetch_en)
    );

endmodule

`default_nettype wire

/* pe_array/processing_element.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module processing_element
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start_mat_mul,
    input  elem_t in_a,
    input  elem_t in_b,
    output elem_t out_a,
    output elem_t out_b,
    output elem_t out_c
);

    elem_t a_q;
    elem_t b_q;
    elem_t prod_q;
    elem_t acc_q;

    // Three MAC stages through the operand, product and accumulator registers.
    // Arithmetic wraps modulo 256 at every step
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            a_q    <= '0;
            b_q    <= '0;
            prod_q <= '0;
            acc_q  <= '0;
        end
        else
        begin
            a_q    <= in_a;
            b_q    <= in_b;
            prod_q <= a_q * b_q;
            acc_q  <= acc_q + prod_q;
        end
    end

    // The operand registers double as the hop to the east and south neighbours
    assign out_a = a_q;
    assign out_b = b_q;
    assign out_c = acc_q;

endmodule

`default_nettype wire

/* pe_array/pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module pe_array
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  lane_vec_t a_edge,
    input  lane_vec_t b_edge,
    output lane_vec_t result_cols [`MAT_MUL_SIZE]
);

    localparam int N = `MAT_MUL_SIZE;

    // a_link[i][j] enters PE(i,j) from the west, b_link[i][j] from the north.
    // The last column of a_link and the last row of b_link run off the mesh
    elem_t a_link [N][N+1];
    elem_t b_link [N+1][N];
    elem_t c_elem [N][N];

    ////////////////////////////////////////////////////////////////////////////
    // Mesh
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < N; i++)
    begin : g_edge
        assign a_link[i][0] = a_edge[i];
        assign b_link[0][i] = b_edge[i];
    end

    for (genvar i = 0; i < N; i++)
    begin : g_row
        for (genvar j = 0; j < N; j++)
        begin : g_col
            processing_element u_pe (
                .clk          (clk),
                .reset        (reset),
                .start_mat_mul(start_mat_mul),
                .in_a         (a_link[i][j]),
                .in_b         (b_link[i][j]),
                .out_a        (a_link[i][j+1]),
                .out_b        (b_link[i+1][j]),
                .out_c        (c_elem[i][j])
            );
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result columns
    ////////////////////////////////////////////////////////////////////////////

    // Column j carries C[i][j] in lane i
    always_comb
    begin
        for (int j = 0; j < N; j++)
        begin
            for (int i = 0; i < N; i++)
                result_cols[j][i] = c_elem[i][j];
        end
    end

endmodule

`default_nettype wire

/* hdl/result_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module result_shifter
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  logic      row_latch_en,
    input  lane_vec_t result_cols [`MAT_MUL_SIZE],
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_c,
    output lane_vec_t c_data_out,
    output addr_t     c_addr,
    output logic      c_data_available
);

    localparam int N         = `MAT_MUL_SIZE;
    localparam int CNT_W     = $clog2(N + 1);
    localparam int RUN_LIMIT = N + 1;

    lane_vec_t        col_q [N];
    logic [CNT_W-1:0] beats_left;

    ////////////////////////////////////////////////////////////////////////////
    // Beat counter and C address
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            beats_left <= '0;
            c_addr     <= address_mat_c;
        end
        else if (row_latch_en)
        begin
            beats_left <= CNT_W'(N);
            c_addr     <= address_mat_c;
        end
        else if (c_data_available)
        begin
            beats_left <= beats_left - 1'b1;
            c_addr     <= c_addr + addr_t'(address_stride_c);
        end
    end

    assign c_data_available = (beats_left != '0);

    ////////////////////////////////////////////////////////////////////////////
    // Column shift register
    ////////////////////////////////////////////////////////////////////////////

    // Column 0 leads, each beat moves the next column to the head
    always_ff @(posedge clk)
    begin
        if (row_latch_en)
        begin
            col_q <= result_cols;
        end
        else if (c_data_available)
        begin
            for (int j = 0; j < N - 1; j++)
                col_q[j] <= col_q[j+1];
            col_q[N-1] <= '0;
        end
    end

    assign c_data_out = col_q[0];

    // No burst is longer than one column per lane
    burst_length: assert property (
        @(posedge clk) disable iff (reset)
        not (c_data_available [*RUN_LIMIT])
    );

endmodule

`default_nettype wire

/* hdl/matmul_4x4_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_4x4_top
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    output logic      done_mat_mul,
    input  addr_t     address_mat_a,
    input  addr_t     address_mat_b,
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_a,
    input  stride_t   address_stride_b,
    input  stride_t   address_stride_c,
    input  lane_vec_t a_data,
    input  lane_vec_t b_data,
    output addr_t     a_addr,
    output addr_t     b_addr,
    output addr_t     c_addr,
    output lane_vec_t c_data_out,
    output logic      c_data_available,
    input  mask_t     validity_mask_a_rows,
    input  mask_t     validity_mask_a_cols_b_rows,
    input  mask_t     validity_mask_b_cols
);

    logic      fetch_en;
    logic      row_latch_en;
    lane_vec_t a_edge;
    lane_vec_t b_edge;
    lane_vec_t result_cols [`MAT_MUL_SIZE];

    matmul_control u_control (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .fetch_en     (fetch_en),
        .row_latch_en (row_latch_en),
        .done_mat_mul (done_mat_mul)
    );

    // A columns feed the mesh rows
    operand_feeder u_feed_a (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .fetch_en     (fetch_en),
        .base_addr    (address_mat_a),
        .stride       (address_stride_a),
        .lane_mask    (validity_mask_a_rows),
        .term_mask    (validity_mask_a_cols_b_rows),
        .mem_data     (a_data),
        .mem_addr     (a_addr),
        .skewed_lanes (a_edge)
    );

    // B rows feed the mesh columns
    operand_feeder u_feed_b (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .fetch_en     (fetch_en),
        .base_addr    (address_mat_b),
        .stride       (address_stride_b),
        .lane_mask    (validity_mask_b_cols),
        .term_mask    (validity_mask_a_cols_b_rows),
        .mem_data     (b_data),
        .mem_addr     (b_addr),
        .skewed_lanes (b_edge)
    );

    pe_array u_pe_array (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .a_edge       (a_edge),
        .b_edge       (b_edge),
        .result_cols  (result_cols)
    );

    result_shifter u_shifter (
        .clk             (clk),
        .reset           (reset),
        .start_mat_mul   (start_mat_mul),
        .row_latch_en    (row_latch_en),
        .result_cols     (result_cols),
        .address_mat_c   (address_mat_c),
        .address_stride_c(address_stride_c),
        .c_data_out      (c_data_out),
        .c_addr          (c_addr),
        .c_data_available(c_data_available)
    );

endmodule

`default_nettype wire

/* sim/matmul_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_checker
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  logic      done_mat_mul,
    input  addr_t     address_mat_a,
    input  addr_t     address_mat_b,
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_a,
    input  stride_t   address_stride_b,
    input  stride_t   address_stride_c,
    input  addr_t     a_addr,
    input  addr_t     b_addr,
    input  addr_t     c_addr,
    input  lane_vec_t c_data_out,
    input  logic      c_data_available,
    input  lane_vec_t exp_cols [`MAT_MUL_SIZE],
    output int        error_count,
    output int        check_count,
    output int        runs_done
);

    localparam int N = `MAT_MUL_SIZE;

    // Cycle number within the run, zero in the first cycle start is high
    int   cyc;
    int   run_errors;
    int   beat;
    logic in_burst;

    initial
    begin
        error_count = 0;
        check_count = 0;
        runs_done   = 0;
        cyc         = 0;
        run_errors  = 0;
    end

    function automatic addr_t step_addr(input addr_t base, input stride_t step, input int k);
        return addr_t'(int'(base) + int'(step) * k);
    endfunction

    task automatic compare_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            run_errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Port checks, sampled mid cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (reset)
        begin
            cyc = 0;
        end
        else if (!start_mat_mul)
        begin
            compare_value("done_mat_mul", done_mat_mul, 32'd0);
            compare_value("c_data_available", c_data_available, 32'd0);
            cyc        = 0;
            run_errors = 0;
        end
        else
        begin
            // Fetch k has its address on the bus in cycle k+1
            if (cyc >= 1 && cyc <= N)
            begin
                compare_value($sformatf("a_addr fetch %0d", cyc - 1), a_addr,
                              step_addr(address_mat_a, address_stride_a, cyc - 1));
                compare_value($sformatf("b_addr fetch %0d", cyc - 1), b_addr,
                              step_addr(address_mat_b, address_stride_b, cyc - 1));
            end

            // Four beats right after the latch strobe
            beat     = cyc - (`LATCH_CYCLE + 1);
            in_burst = (beat >= 0) && (beat < N);
            compare_value("c_data_available", c_data_available, in_burst);
            if (in_burst)
            begin
                compare_value($sformatf("c_data_out beat %0d", beat), c_data_out,
                              exp_cols[beat]);
                compare_value($sformatf("c_addr beat %0d", beat), c_addr,
                              step_addr(address_mat_c, address_stride_c, beat));
            end

            compare_value("done_mat_mul", done_mat_mul, cyc == `DONE_CYCLE);
            if (cyc == `DONE_CYCLE)
            begin
                runs_done++;
                if (run_errors == 0)
                    $display("run %0d: ok", runs_done);
                else
                    $display("run %0d: %0d errors", runs_done, run_errors);
            end
            cyc++;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_matmul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module tb_matmul
    import matmul_pkg::*;
();

    localparam int N           = `MAT_MUL_SIZE;
    localparam int NUM_RUNS    = 10;
    localparam int CYCLE_LIMIT = 40 * NUM_RUNS + 100;

    logic        clk;
    logic        reset;
    logic        start_mat_mul;
    logic        done_mat_mul;
    addr_t       address_mat_a;
    addr_t       address_mat_b;
    addr_t       address_mat_c;
    stride_t     address_stride_a;
    stride_t     address_stride_b;
    stride_t     address_stride_c;
    lane_vec_t   a_data;
    lane_vec_t   b_data;
    addr_t       a_addr;
    addr_t       b_addr;
    addr_t       c_addr;
    lane_vec_t   c_data_out;
    logic        c_data_available;
    mask_t       validity_mask_a_rows;
    mask_t       validity_mask_a_cols_b_rows;
    mask_t       validity_mask_b_cols;

    int          error_count;
    int          check_count;
    int          runs_done;
    int          cycle_count = 0;

    // Word memories for A and B indexed by address
    lane_vec_t   mem_a [addr_t];
    lane_vec_t   mem_b [addr_t];
    addr_t       a_addr_seen = '0;
    addr_t       b_addr_seen = '0;
    elem_t       mat_a [N][N];
    elem_t       mat_b [N][N];
    lane_vec_t   exp_cols [N];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    matmul_4x4_top UUT (
        .clk                        (clk),
        .reset                      (reset),
        .start_mat_mul              (start_mat_mul),
        .done_mat_mul               (done_mat_mul),
        .address_mat_a              (address_mat_a),
        .address_mat_b              (address_mat_b),
        .address_mat_c              (address_mat_c),
        .address_stride_a           (address_stride_a),
        .address_stride_b           (address_stride_b),
        .address_stride_c           (address_stride_c),
        .a_data                     (a_data),
        .b_data                     (b_data),
        .a_addr                     (a_addr),
        .b_addr                     (b_addr),
        .c_addr                     (c_addr),
        .c_data_out                 (c_data_out),
        .c_data_available           (c_data_available),
        .validity_mask_a_rows       (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows(validity_mask_a_cols_b_rows),
        .validity_mask_b_cols       (validity_mask_b_cols)
    );

    matmul_checker u_checker (
        .clk             (clk),
        .reset           (reset),
        .start_mat_mul   (start_mat_mul),
        .done_mat_mul    (done_mat_mul),
        .address_mat_a   (address_mat_a),
        .address_mat_b   (address_mat_b),
        .address_mat_c   (address_mat_c),
        .address_stride_a(address_stride_a),
        .address_stride_b(address_stride_b),
        .address_stride_c(address_stride_c),
        .a_addr          (a_addr),
        .b_addr          (b_addr),
        .c_addr          (c_addr),
        .c_data_out      (c_data_out),
        .c_data_available(c_data_available),
        .exp_cols        (exp_cols),
        .error_count     (error_count),
        .check_count     (check_count),
        .runs_done       (runs_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////////////////////

    // Words never written read back as a scramble of the full address
    function automatic lane_vec_t fill_word(input addr_t addr, input logic [31:0] salt);
        return lane_vec_t'((32'(addr) * 32'h9e37_79b1) ^ salt);
    endfunction

    function automatic lane_vec_t read_a(input addr_t addr);
        if (mem_a.exists(addr))
            return mem_a[addr];
        return fill_word(addr, 32'h0a5a_c3e1);
    endfunction

    function automatic lane_vec_t read_b(input addr_t addr);
        if (mem_b.exists(addr))
            return mem_b[addr];
        return fill_word(addr, 32'h71b4_2d96);
    endfunction

    function automatic addr_t step_addr(input addr_t base, input stride_t step, input int k);
        return addr_t'(int'(base) + int'(step) * k);
    endfunction

    // One cycle of read latency
    always @(negedge clk)
    begin
        a_addr_seen <= a_addr;
        b_addr_seen <= b_addr;
    end

    always @(posedge clk)
    begin
        #1;
        a_data = read_a(a_addr_seen);
        b_data = read_b(b_addr_seen);
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operands and reference product
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_operands();
        addr_t     addr;
        lane_vec_t word;
        for (int k = 0; k < N; k++)
        begin
            mem_a[step_addr(address_mat_a, address_stride_a, k)] = lane_vec_t'($urandom);
            mem_b[step_addr(address_mat_b, address_stride_b, k)] = lane_vec_t'($urandom);
        end
        // Reading back after all writes lets a zero stride fold onto one word
        for (int k = 0; k < N; k++)
        begin
            addr = step_addr(address_mat_a, address_stride_a, k);
            word = read_a(addr);
            for (int i = 0; i < N; i++)
                mat_a[i][k] = word[i];
            addr = step_addr(address_mat_b, address_stride_b, k);
            word = read_b(addr);
            for (int j = 0; j < N; j++)
                mat_b[k][j] = word[j];
        end
    endtask

    // C[i][j] sums the valid inner terms of row i of A and column j of B
    task automatic compute_expected();
        int acc;
        for (int j = 0; j < N; j++)
        begin
            for (int i = 0; i < N; i++)
            begin
                acc = 0;
                for (int k = 0; k < N; k++)
                begin
                    if (validity_mask_a_cols_b_rows[k] && validity_mask_a_rows[i]
                        && validity_mask_b_cols[j])
                        acc = acc + int'(mat_a[i][k]) * int'(mat_b[k][j]);
                end
                exp_cols[j][i] = elem_t'(acc);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Runs
    ////////////////////////////////////////////////////////////////////////////

    // Start is low for exactly one cycle before each run
    task automatic run_block(
        input addr_t   base_a,
        input addr_t   base_b,
        input addr_t   base_c,
        input stride_t step_a,
        input stride_t step_b,
        input stride_t step_c,
        input mask_t   rows,
        input mask_t   terms,
        input mask_t   cols
    );
        @(posedge clk);
        #1;
        start_mat_mul               = 1'b0;
        address_mat_a               = base_a;
        address_mat_b               = base_b;
        address_mat_c               = base_c;
        address_stride_a            = step_a;
        address_stride_b            = step_b;
        address_stride_c            = step_c;
        validity_mask_a_rows        = rows;
        validity_mask_a_cols_b_rows = terms;
        validity_mask_b_cols        = cols;
        load_operands();
        compute_expected();
        @(posedge clk);
        #1;
        start_mat_mul = 1'b1;
        do
            @(negedge clk);
        while (!done_mat_mul);
    endtask

    task automatic run_random(input logic random_masks);
        mask_t rows;
        mask_t terms;
        mask_t cols;
        rows  = random_masks ? mask_t'($urandom) : 4'hf;
        terms = random_masks ? mask_t'($urandom) : 4'hf;
        cols  = random_masks ? mask_t'($urandom) : 4'hf;
        run_block(addr_t'($urandom), addr_t'($urandom), addr_t'($urandom),
                  stride_t'($urandom_range(255, 2)), stride_t'($urandom_range(255, 2)),
                  stride_t'($urandom_range(255, 2)), rows, terms, cols);
    endtask

    initial
    begin
        reset                       = 1'b1;
        start_mat_mul               = 1'b0;
        address_mat_a               = '0;
        address_mat_b               = '0;
        address_mat_c               = '0;
        address_stride_a            = '0;
        address_stride_b            = '0;
        address_stride_c            = '0;
        a_data                      = '0;
        b_data                      = '0;
        validity_mask_a_rows        = '0;
        validity_mask_a_cols_b_rows = '0;
        validity_mask_b_cols        = '0;
        for (int j = 0; j < N; j++)
            exp_cols[j] = '0;
        void'($urandom(45823));

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Nothing may come out before the first start
        repeat (8) @(posedge clk);
        $display("idle after reset: %0d errors", error_count);

        // Dense products with unit strides
        run_block(10'h000, 10'h100, 10'h200, 8'd1, 8'd1, 8'd1, 4'hf, 4'hf, 4'hf);
        run_block(10'h000, 10'h100, 10'h200, 8'd1, 8'd1, 8'd1, 4'hf, 4'hf, 4'hf);
        repeat (3) run_random(1'b0);
        repeat (5) run_random(1'b1);

        @(posedge clk);
        #1;
        start_mat_mul = 1'b0;
        repeat (3) @(posedge clk);

        $display("runs %0d of %0d, checks %0d, errors %0d",
                 runs_done, NUM_RUNS, check_count, error_count);
        if (error_count == 0 && runs_done == NUM_RUNS)
        begin
            $display("Regression passed");
        end
        else
        begin
            if (runs_done != NUM_RUNS)
                $display("Only %0d of %0d runs reached done", runs_done, NUM_RUNS);
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/matmul_pkg.sv
hdl/matmul_control.sv
hdl/operand_feeder.sv
pe_array/processing_element.sv
pe_array/pe_array.sv
hdl/result_shifter.sv
hdl/matmul_4x4_top.sv
sim/matmul_checker.sv
sim/tb_matmul.sv
